/* hdl/tl_cfg.svh */
`ifndef TL_CFG_SVH
`define TL_CFG_SVH

// Data path
`define TL_ADDR_W   32      // Address and data word
`define TL_OFFS_W   4       // Byte offset inside a 16-byte line
`define TL_REG_W    5
`define TL_ID_W     4

// Fully associative tag array
`define TL_WAYS     4
`define TL_IDX_W    2

// Store buffer entries
`define TL_SB_DEPTH 2

`endif

/* hdl/tl_pkg.sv */
`include "tl_cfg.svh"

package tl_pkg;

typedef logic [`TL_ADDR_W-1:0]            word_t;
typedef logic [`TL_ADDR_W-`TL_OFFS_W-1:0] line_tag_t;
typedef logic [`TL_IDX_W-1:0]             line_idx_t;
typedef logic [`TL_REG_W-1:0]             reg_addr_t;
typedef logic [`TL_ID_W-1:0]              instr_id_t;

// From execute, held by execute while the stage stalls
typedef struct packed {
    logic      rd;          // Load strobe
    logic      wr;          // Store strobe
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     addr;
    word_t     st_data;
    instr_id_t instr_id;
} tl_req_t;

// To the memory stage
typedef struct packed {
    logic      rd;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     addr;
    line_idx_t addr_index;  // Tag entry that hit
    logic      sb_hit;
    word_t     load_data;   // Forwarded from the store buffer
    logic      sb_merge;
    logic      flush;       // Oldest buffered store goes to the cache
    word_t     flush_addr;
    word_t     flush_data;
    instr_id_t instr_id;
} tl_resp_t;

typedef enum logic [1:0] {
    TL_IDLE,
    MISS_IN_FLIGHT,
    HAZARD_DC_MISS,
    HAZARD_SB_TROUBLE
} tl_state_e;

endpackage

/* hdl/dcache_tag.sv */
`timescale 1ns/100ps
`include "tl_cfg.svh"

module dcache_tag
    import tl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_i,
    input  line_tag_t tag_i,
    input  logic      fill_i,
    input  line_idx_t fill_idx_i,
    input  line_tag_t fill_tag_i,
    output logic      hit_o,
    output logic      miss_o,
    output line_idx_t hit_idx_o,
    output word_t     victim_addr_o
);

logic [`TL_WAYS-1:0] valid_q;
line_tag_t           tag_q [`TL_WAYS];
logic [`TL_WAYS-1:0] match;

// Compare the request tag against all entries at once
always_comb begin
    hit_idx_o = '0;
    for (int i = 0; i < `TL_WAYS; i++) begin
        match[i] = valid_q[i] && (tag_q[i] == tag_i);
        if (match[i]) begin
            hit_idx_o = line_idx_t'(i);
        end
    end
end

assign hit_o  = req_i & (|match);
assign miss_o = req_i & ~(|match);

// Line that the fill is about to replace
assign victim_addr_o = {tag_q[fill_idx_i], {`TL_OFFS_W{1'b0}}};

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        valid_q <= '0;
    end else if (fill_i) begin
        valid_q[fill_idx_i] <= 1'b1;
    end
end

always_ff @(posedge clk_i) begin
    if (fill_i) begin
        tag_q[fill_idx_i] <= fill_tag_i;    // New line from the MMU
    end
end

// A line sits in one entry at most, so a hit names a single index
a_single_match: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(match)
);

endmodule

/* hdl/store_buffer.sv */
`timescale 1ns/100ps
`include "tl_cfg.svh"

module store_buffer
    import tl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      store_i,
    input  logic      load_i,
    input  word_t     addr_i,
    input  word_t     data_i,
    input  instr_id_t instr_id_i,
    input  logic      flush_i,
    output logic      hit_o,
    output logic      miss_o,
    output logic      trouble_o,
    output logic      merge_o,
    output word_t     load_data_o,
    output logic      flush_valid_o,
    output word_t     flush_addr_o,
    output word_t     flush_data_o,
    output instr_id_t flush_id_o
);

localparam int PTR_W = $clog2(`TL_SB_DEPTH);

logic [`TL_SB_DEPTH-1:0] valid_q;
word_t                   addr_q [`TL_SB_DEPTH];
word_t                   data_q [`TL_SB_DEPTH];
instr_id_t               id_q   [`TL_SB_DEPTH];
logic [PTR_W-1:0]        head_q;    // Oldest entry
logic [PTR_W-1:0]        tail_q;    // Next free entry
logic [`TL_SB_DEPTH-1:0] match;
logic [PTR_W-1:0]        match_idx;
logic                    any_match;
logic                    full;
logic                    empty;
logic                    push;
logic                    pop;

// Word compare, byte offset ignored
always_comb begin
    match_idx = '0;
    for (int i = 0; i < `TL_SB_DEPTH; i++) begin
        match[i] = valid_q[i] && (addr_q[i][`TL_ADDR_W-1:2] == addr_i[`TL_ADDR_W-1:2]);
        if (match[i]) begin
            match_idx = PTR_W'(i);
        end
    end
end

assign any_match = |match;
assign full      = &valid_q;
assign empty     = ~(|valid_q);

assign hit_o     = (load_i | store_i) & any_match;
assign miss_o    = load_i & ~any_match;
assign merge_o   = store_i & any_match;
assign trouble_o = store_i & ~any_match & full;    // Store has nowhere to go

assign push = store_i & ~any_match & ~full;
assign pop  = flush_i & valid_q[head_q];

assign load_data_o   = data_q[match_idx];
assign flush_valid_o = valid_q[head_q];
assign flush_addr_o  = addr_q[head_q];
assign flush_data_o  = data_q[head_q];
assign flush_id_o    = id_q[head_q];

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        valid_q <= '0;
        head_q  <= '0;
        tail_q  <= '0;
    end else begin
        if (push) begin
            valid_q[tail_q] <= 1'b1;
            tail_q          <= tail_q + 1'b1;
        end
        if (pop) begin
            valid_q[head_q] <= 1'b0;
            head_q          <= head_q + 1'b1;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (push) begin
        addr_q[tail_q] <= addr_i;
        data_q[tail_q] <= data_i;
        id_q[tail_q]   <= instr_id_i;
    end else if (merge_o) begin
        data_q[match_idx] <= data_i;    // Younger store wins
        id_q[match_idx]   <= instr_id_i;
    end
end

// A new store always lands in a free entry
a_push_free: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push |-> !valid_q[tail_q]
);

// Flush requests from the controller only reach a non-empty buffer
a_no_flush_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> !empty
);

endmodule

/* hdl/tl_ctrl.sv */
`timescale 1ns/100ps
`include "tl_cfg.svh"

module tl_ctrl
    import tl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  tl_req_t   req_i,
    input  logic      dc_hit_i,
    input  logic      dc_miss_i,
    input  logic      sb_hit_i,
    input  logic      sb_miss_i,
    input  logic      sb_trouble_i,
    input  logic      sb_flush_valid_i,
    input  logic      mmu_data_rdy_i,
    input  logic      store_permission_i,
    output logic      accept_o,
    output logic      hazard_o,
    output logic      flush_o,
    output tl_state_e state_o
);

tl_state_e state_q;
tl_state_e state_d;
line_tag_t inflight_tag_q;
logic      inflight_vld_q;
line_tag_t req_tag;
logic      any_req;
logic      other_line;
logic      same_line;
logic      st_miss;
logic      ld_unserved;
logic      mif_stall;
logic      flush_chance;

assign req_tag    = req_i.addr[`TL_ADDR_W-1:`TL_OFFS_W];
assign any_req    = req_i.rd | req_i.wr;
assign other_line = inflight_vld_q & (inflight_tag_q != req_tag);
assign same_line  = inflight_vld_q & (inflight_tag_q == req_tag);

assign st_miss     = req_i.wr & dc_miss_i & ~sb_hit_i;  // Merging stores need no new line
assign ld_unserved = req_i.rd & dc_miss_i & sb_miss_i;

// Only accesses that cannot disturb the pending line may proceed
assign mif_stall = (req_i.wr & other_line)
                 | (req_i.rd & ~dc_hit_i & other_line)
                 | (ld_unserved & same_line)
                 | sb_trouble_i;

assign accept_o = ((state_q == TL_IDLE) | (state_q == MISS_IN_FLIGHT)) & any_req;
assign flush_o  = flush_chance & sb_flush_valid_i;
assign state_o  = state_q;

always_comb begin
    state_d      = state_q;
    hazard_o     = 1'b0;
    flush_chance = 1'b0;
    unique case (state_q)
        TL_IDLE: begin
            hazard_o     = sb_trouble_i | ld_unserved;
            flush_chance = store_permission_i & ~any_req;   // Idle slot only
            if (st_miss) begin
                state_d = sb_trouble_i ? HAZARD_SB_TROUBLE : MISS_IN_FLIGHT;
            end else if (ld_unserved) begin
                state_d = HAZARD_DC_MISS;
            end else if (sb_trouble_i) begin
                state_d = HAZARD_SB_TROUBLE;
            end
        end
        MISS_IN_FLIGHT: begin
            hazard_o = mif_stall;
            if (mmu_data_rdy_i) begin
                state_d = TL_IDLE;
            end else if (mif_stall) begin
                state_d = HAZARD_DC_MISS;
            end
        end
        HAZARD_DC_MISS: begin
            hazard_o = 1'b1;
            if (mmu_data_rdy_i) begin
                state_d = TL_IDLE;
            end
        end
        HAZARD_SB_TROUBLE: begin
            hazard_o     = 1'b1;
            flush_chance = store_permission_i;
            if (!sb_trouble_i) begin
                state_d = TL_IDLE;
            end
        end
        default: state_d = TL_IDLE;
    endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q        <= TL_IDLE;
        inflight_tag_q <= '0;
        inflight_vld_q <= 1'b0;
    end else begin
        state_q <= state_d;
        if (state_q == TL_IDLE) begin
            inflight_tag_q <= req_tag;  // Frozen while the line is pending
            inflight_vld_q <= st_miss;
        end
    end
end

// A trouble stall always leaves a buffered store for the flush to drain
a_trouble_has_entry: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    state_q == HAZARD_SB_TROUBLE |-> sb_flush_valid_i
);

// The pending line is always known while the miss is in flight
a_mif_tag_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    state_q == MISS_IN_FLIGHT |-> inflight_vld_q
);

endmodule

/* hdl/tl_stage.sv */
`timescale 1ns/100ps
`include "tl_cfg.svh"

module tl_stage
    import tl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  tl_req_t   req_i,
    input  logic      store_permission_i,
    input  logic      mmu_data_rdy_i,
    input  line_idx_t mmu_lru_index_i,
    input  word_t     mmu_fill_addr_i,
    output tl_resp_t  resp_o,
    output logic      mmu_miss_o,
    output word_t     mmu_addr_o,
    output logic      mmu_cache_access_o,
    output logic      pipeline_hazard_o
);

logic      dc_hit, dc_miss;
line_idx_t dc_hit_idx;
word_t     dc_victim;
logic      sb_store;
logic      sb_hit, sb_miss, sb_trouble, sb_merge;
word_t     sb_load_data;
logic      sb_flush_valid;
word_t     sb_flush_addr, sb_flush_data;
instr_id_t sb_flush_id;
logic      accept, hazard, flush;
tl_state_e state;
tl_resp_t  resp_d, resp_q;

// Held store keeps probing the full buffer until a flush frees an entry
assign sb_store = req_i.wr & (accept | (state == HAZARD_SB_TROUBLE));

assign mmu_miss_o         = dc_miss & ~sb_hit & (accept | (state == HAZARD_DC_MISS));
assign mmu_addr_o         = mmu_data_rdy_i ? dc_victim : req_i.addr;   // Victim for writeback
assign mmu_cache_access_o = accept;
assign pipeline_hazard_o  = hazard;
assign resp_o             = resp_q;

dcache_tag i_dcache_tag (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i.rd | req_i.wr),
    .tag_i         (req_i.addr[`TL_ADDR_W-1:`TL_OFFS_W]),
    .fill_i        (mmu_data_rdy_i),
    .fill_idx_i    (mmu_lru_index_i),
    .fill_tag_i    (mmu_fill_addr_i[`TL_ADDR_W-1:`TL_OFFS_W]),
    .hit_o         (dc_hit),
    .miss_o        (dc_miss),
    .hit_idx_o     (dc_hit_idx),
    .victim_addr_o (dc_victim)
);

store_buffer i_store_buffer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .store_i       (sb_store),
    .load_i        (req_i.rd),
    .addr_i        (req_i.addr),
    .data_i        (req_i.st_data),
    .instr_id_i    (req_i.instr_id),
    .flush_i       (flush),
    .hit_o         (sb_hit),
    .miss_o        (sb_miss),
    .trouble_o     (sb_trouble),
    .merge_o       (sb_merge),
    .load_data_o   (sb_load_data),
    .flush_valid_o (sb_flush_valid),
    .flush_addr_o  (sb_flush_addr),
    .flush_data_o  (sb_flush_data),
    .flush_id_o    (sb_flush_id)
);

tl_ctrl i_tl_ctrl (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .req_i              (req_i),
    .dc_hit_i           (dc_hit),
    .dc_miss_i          (dc_miss),
    .sb_hit_i           (sb_hit),
    .sb_miss_i          (sb_miss),
    .sb_trouble_i       (sb_trouble),
    .sb_flush_valid_i   (sb_flush_valid),
    .mmu_data_rdy_i     (mmu_data_rdy_i),
    .store_permission_i (store_permission_i),
    .accept_o           (accept),
    .hazard_o           (hazard),
    .flush_o            (flush),
    .state_o            (state)
);

// Bubble by default, then fill in what this cycle carries
always_comb begin
    resp_d          = resp_q;
    resp_d.rd       = 1'b0;
    resp_d.rf_we    = 1'b0;
    resp_d.sb_hit   = 1'b0;
    resp_d.sb_merge = 1'b0;
    resp_d.flush    = flush;
    if (flush) begin
        resp_d.flush_addr = sb_flush_addr;
        resp_d.flush_data = sb_flush_data;
        resp_d.instr_id   = sb_flush_id;
    end
    if (!hazard) begin
        resp_d.rf_we      = req_i.rf_we;
        resp_d.rf_waddr   = req_i.rf_waddr;
        resp_d.addr       = req_i.addr;
        resp_d.addr_index = dc_hit_idx;
        resp_d.sb_merge   = sb_merge;
        if (!flush) begin
            resp_d.rd       = req_i.rd;
            resp_d.instr_id = req_i.instr_id;
            if (sb_hit) begin
                resp_d.sb_hit    = 1'b1;    // Served by the buffer
                resp_d.load_data = sb_load_data;
            end
        end
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        resp_q <= '0;
    end else begin
        resp_q <= resp_d;
    end
end

endmodule

/* verif/tl_checker.sv */
`timescale 1ns/100ps

module tl_checker
    import tl_pkg::*;
(
    input  logic       clk_i,
    input  logic       check_en_i,
    input  logic       hazard_i,
    input  logic       mmu_miss_i,
    input  logic       access_i,
    input  word_t      mmu_addr_i,
    input  tl_resp_t   resp_i,
    input  logic       exp_hazard_i,
    input  logic       exp_miss_i,
    input  logic       exp_access_i,
    input  word_t      exp_mmu_addr_i,
    input  logic       addr_chk_i,
    input  tl_resp_t   exp_resp_i,
    input  logic [2:0] dc_mask_i,   // Bit 0 load data, bit 1 index, bit 2 flush fields
    output int         err_cnt_o,
    output int         chk_cnt_o
);

int err_cnt = 0;
int chk_cnt = 0;

assign err_cnt_o = err_cnt;
assign chk_cnt_o = chk_cnt;

task automatic compare_bit(input string what, input logic got, input logic want);
    chk_cnt++;
    if (got !== want) begin
        err_cnt++;
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, want);
    end
endtask

task automatic compare_word(input string what, input word_t got, input word_t want);
    chk_cnt++;
    if (got !== want) begin
        err_cnt++;
        $display("ERR %0t: %s is 0x%h, expected 0x%h", $time, what, got, want);
    end
endtask

// Inputs change on the rising edge, so everything is settled here
always @(negedge clk_i) begin
    if (check_en_i) begin
        compare_bit("pipeline_hazard_o", hazard_i, exp_hazard_i);
        compare_bit("mmu_miss_o", mmu_miss_i, exp_miss_i);
        compare_bit("mmu_cache_access_o", access_i, exp_access_i);
        if (addr_chk_i) begin
            compare_word("mmu_addr_o", mmu_addr_i, exp_mmu_addr_i);
        end
        compare_bit("resp.rd", resp_i.rd, exp_resp_i.rd);
        compare_bit("resp.rf_we", resp_i.rf_we, exp_resp_i.rf_we);
        compare_bit("resp.sb_hit", resp_i.sb_hit, exp_resp_i.sb_hit);
        compare_bit("resp.sb_merge", resp_i.sb_merge, exp_resp_i.sb_merge);
        compare_bit("resp.flush", resp_i.flush, exp_resp_i.flush);
        if (exp_resp_i.rf_we) begin
            compare_word("resp.rf_waddr", word_t'(resp_i.rf_waddr),
                         word_t'(exp_resp_i.rf_waddr));
        end
        if (!dc_mask_i[0]) begin
            compare_word("resp.load_data", resp_i.load_data, exp_resp_i.load_data);
        end
        if (!dc_mask_i[1]) begin
            compare_word("resp.addr_index", word_t'(resp_i.addr_index),
                         word_t'(exp_resp_i.addr_index));
        end
        if (!dc_mask_i[2]) begin
            compare_word("resp.flush_addr", resp_i.flush_addr, exp_resp_i.flush_addr);
            compare_word("resp.flush_data", resp_i.flush_data, exp_resp_i.flush_data);
        end
    end
end

endmodule

/* verif/tl_stage_tb.sv */
`timescale 1ns/100ps

module tl_stage_tb
    import tl_pkg::*;
();

localparam int CLK_PERIOD = 10;

// Don't-care masks, named after the field that stays checked
localparam logic [2:0] DC_ALL   = 3'b111;
localparam logic [2:0] CHK_DATA = 3'b110;
localparam logic [2:0] CHK_IDX  = 3'b101;
localparam logic [2:0] CHK_FL   = 3'b011;

localparam word_t ADDR_A  = 32'h0000_1000;
localparam word_t ADDR_C  = 32'h0000_4000;
localparam word_t ADDR_S  = 32'h0000_3004;
localparam word_t ADDR_W1 = 32'h0000_1008;  // Same line as ADDR_A
localparam word_t ADDR_W2 = 32'h0000_100c;

typedef struct packed {
    tl_req_t    req;
    logic       perm;
    logic       rdy;
    line_idx_t  lru;
    word_t      fill_addr;
    logic       hazard;
    logic       miss;
    logic       access;
    logic       addr_chk;
    word_t      mmu_addr;
    tl_resp_t   resp;       // What this row's cycle puts in the response register
    logic [2:0] dc;
} row_t;

logic       clk = 1'b0;
logic       rst_n;
tl_req_t    req;
logic       perm;
logic       rdy;
line_idx_t  lru;
word_t      fill_addr;
tl_resp_t   resp;
logic       mmu_miss;
word_t      mmu_addr;
logic       mmu_access;
logic       hazard;
logic       check_en;
logic       exp_hazard;
logic       exp_miss;
logic       exp_access;
word_t      exp_mmu_addr;
logic       addr_chk;
tl_resp_t   exp_resp;
logic [2:0] dc_mask;
int         err_cnt;
int         chk_cnt;
row_t       tbl [$];
word_t      data_s1, data_s2, data_w1, data_w2;
reg_addr_t  reg_a, reg_s, reg_c;

always #(CLK_PERIOD / 2) clk = ~clk;

tl_stage i_tl_stage (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .req_i              (req),
    .store_permission_i (perm),
    .mmu_data_rdy_i     (rdy),
    .mmu_lru_index_i    (lru),
    .mmu_fill_addr_i    (fill_addr),
    .resp_o             (resp),
    .mmu_miss_o         (mmu_miss),
    .mmu_addr_o         (mmu_addr),
    .mmu_cache_access_o (mmu_access),
    .pipeline_hazard_o  (hazard)
);

tl_checker i_tl_checker (
    .clk_i          (clk),
    .check_en_i     (check_en),
    .hazard_i       (hazard),
    .mmu_miss_i     (mmu_miss),
    .access_i       (mmu_access),
    .mmu_addr_i     (mmu_addr),
    .resp_i         (resp),
    .exp_hazard_i   (exp_hazard),
    .exp_miss_i     (exp_miss),
    .exp_access_i   (exp_access),
    .exp_mmu_addr_i (exp_mmu_addr),
    .addr_chk_i     (addr_chk),
    .exp_resp_i     (exp_resp),
    .dc_mask_i      (dc_mask),
    .err_cnt_o      (err_cnt),
    .chk_cnt_o      (chk_cnt)
);

function automatic tl_req_t load_req(word_t addr, reg_addr_t rd_reg);
    tl_req_t rq;
    rq          = '0;
    rq.rd       = 1'b1;
    rq.rf_we    = 1'b1;
    rq.rf_waddr = rd_reg;
    rq.addr     = addr;
    return rq;
endfunction

function automatic tl_req_t store_req(word_t addr, word_t data);
    tl_req_t rq;
    rq         = '0;
    rq.wr      = 1'b1;
    rq.addr    = addr;
    rq.st_data = data;
    return rq;
endfunction

function automatic tl_resp_t load_resp(logic sb_hit, word_t data, line_idx_t idx,
                                       reg_addr_t rd_reg);
    tl_resp_t rs;
    rs            = '0;
    rs.rd         = 1'b1;
    rs.rf_we      = 1'b1;
    rs.rf_waddr   = rd_reg;
    rs.sb_hit     = sb_hit;
    rs.load_data  = data;
    rs.addr_index = idx;
    return rs;
endfunction

// A store that hits the buffer also shows up as a buffer hit
function automatic tl_resp_t merge_resp();
    tl_resp_t rs;
    rs          = '0;
    rs.sb_hit   = 1'b1;
    rs.sb_merge = 1'b1;
    return rs;
endfunction

function automatic tl_resp_t flush_resp(word_t addr, word_t data);
    tl_resp_t rs;
    rs            = '0;
    rs.flush      = 1'b1;
    rs.flush_addr = addr;
    rs.flush_data = data;
    return rs;
endfunction

// ctl is {store permission, MMU ready, expected hazard, expected miss, expected access}
task automatic add_row(tl_req_t rq, logic [4:0] ctl, line_idx_t fill_idx, word_t fill,
                       tl_resp_t rs, logic [2:0] dc);
    row_t row;
    row.req       = rq;
    row.perm      = ctl[4];
    row.rdy       = ctl[3];
    row.hazard    = ctl[2];
    row.miss      = ctl[1];
    row.access    = ctl[0];
    row.lru       = fill_idx;
    row.fill_addr = fill;
    row.mmu_addr  = rq.addr;
    row.addr_chk  = ~ctl[3];    // Victim of an empty entry is undefined
    row.resp      = rs;
    row.dc        = dc;
    tbl.push_back(row);
endtask

// The last row fills over a valid entry, so its victim is known
task automatic expect_victim(word_t victim);
    row_t row;
    row          = tbl.pop_back();
    row.mmu_addr = victim;
    row.addr_chk = 1'b1;
    tbl.push_back(row);
endtask

task automatic build_table();
    data_s1 = $urandom();
    data_s2 = $urandom();
    data_w1 = $urandom();
    data_w2 = $urandom();
    reg_a   = reg_addr_t'($urandom());
    reg_s   = reg_addr_t'($urandom());
    reg_c   = reg_addr_t'($urandom());
    add_row('0, 5'b00000, 2'd0, '0, '0, DC_ALL);
    // Load miss on an empty cache waits for the fill
    add_row(load_req(ADDR_A, reg_a), 5'b00111, 2'd0, '0, '0, DC_ALL);
    add_row(load_req(ADDR_A, reg_a), 5'b00110, 2'd0, '0, '0, DC_ALL);
    add_row(load_req(ADDR_A, reg_a), 5'b01110, 2'd2, ADDR_A, '0, DC_ALL);
    add_row(load_req(ADDR_A, reg_a), 5'b00001, 2'd0, '0,
            load_resp(1'b0, '0, 2'd2, reg_a), CHK_IDX);
    // Store miss goes in flight, buffer forwards and merges
    add_row(store_req(ADDR_S, data_s1), 5'b00011, 2'd0, '0, '0, DC_ALL);
    add_row(load_req(ADDR_S, reg_s), 5'b00001, 2'd0, '0,
            load_resp(1'b1, data_s1, 2'd0, reg_s), CHK_DATA);
    add_row(store_req(ADDR_S, data_s2), 5'b00001, 2'd0, '0, merge_resp(), DC_ALL);
    add_row(load_req(ADDR_S, reg_s), 5'b00001, 2'd0, '0,
            load_resp(1'b1, data_s2, 2'd0, reg_s), CHK_DATA);
    // Other line misses while the store line is pending
    add_row(load_req(ADDR_C, reg_c), 5'b00111, 2'd0, '0, '0, DC_ALL);
    add_row(load_req(ADDR_C, reg_c), 5'b00110, 2'd0, '0, '0, DC_ALL);
    add_row(load_req(ADDR_C, reg_c), 5'b01110, 2'd0, ADDR_C, '0, DC_ALL);
    add_row(load_req(ADDR_C, reg_c), 5'b00001, 2'd0, '0,
            load_resp(1'b0, '0, 2'd0, reg_c), CHK_IDX);
    // Full buffer, third store waits for permission
    add_row(store_req(ADDR_W1, data_w1), 5'b00001, 2'd0, '0, '0, DC_ALL);
    add_row(store_req(ADDR_W2, data_w2), 5'b00101, 2'd0, '0, '0, DC_ALL);
    add_row(store_req(ADDR_W2, data_w2), 5'b00100, 2'd0, '0, '0, DC_ALL);
    add_row(store_req(ADDR_W2, data_w2), 5'b10100, 2'd0, '0,
            flush_resp(ADDR_S, data_s2), CHK_FL);
    add_row(store_req(ADDR_W2, data_w2), 5'b10100, 2'd0, '0,
            flush_resp(ADDR_W1, data_w1), CHK_FL);
    add_row(store_req(ADDR_W2, data_w2), 5'b10001, 2'd0, '0, merge_resp(), DC_ALL);
    add_row('0, 5'b10000, 2'd0, '0, flush_resp(ADDR_W2, data_w2), CHK_FL);
    add_row('0, 5'b00000, 2'd0, '0, '0, DC_ALL);
    // Refill of the ADDR_A entry hands back that line as the victim
    add_row('0, 5'b01000, 2'd2, ADDR_S, '0, DC_ALL);
    expect_victim(ADDR_A);
endtask

initial begin
    row_t prev;
    row_t cur;
    void'($urandom(65));
    rst_n        = 1'b0;
    req          = '0;
    perm         = 1'b0;
    rdy          = 1'b0;
    lru          = '0;
    fill_addr    = '0;
    check_en     = 1'b0;
    exp_hazard   = 1'b0;
    exp_miss     = 1'b0;
    exp_access   = 1'b0;
    exp_mmu_addr = '0;
    addr_chk     = 1'b0;
    exp_resp     = '0;
    dc_mask      = DC_ALL;
    prev         = '0;              // Reset value of the response register
    prev.dc      = DC_ALL;
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // One idle cycle past the table to see the last response
    for (int i = 0; i <= tbl.size(); i++) begin
        cur = (i < tbl.size()) ? tbl[i] : row_t'('0);
        @(posedge clk);
        req          <= cur.req;
        perm         <= cur.perm;
        rdy          <= cur.rdy;
        lru          <= cur.lru;
        fill_addr    <= cur.fill_addr;
        check_en     <= 1'b1;
        exp_hazard   <= cur.hazard;
        exp_miss     <= cur.miss;
        exp_access   <= cur.access;
        exp_mmu_addr <= cur.mmu_addr;
        addr_chk     <= cur.addr_chk;
        exp_resp     <= prev.resp;  // Response lags by one cycle
        dc_mask      <= prev.dc;
        prev          = cur;
    end
    @(negedge clk);
    #1;
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

// Watchdog
initial begin
    #1;
    #((tbl.size() + 20) * CLK_PERIOD);
    $display("Timeout: the stimulus table did not finish in time");
    $display("** FAIL **");
    $finish;
end

endmodule

/* vlog.f */
+incdir+hdl
hdl/tl_pkg.sv
hdl/dcache_tag.sv
hdl/store_buffer.sv
hdl/tl_ctrl.sv
hdl/tl_stage.sv
verif/tl_checker.sv
verif/tl_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build the tag-lookup testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
    --top-module tl_stage_tb -o tl_sim > build.log 2>&1 \
    && ./obj_dir/tl_sim > sim.log 2>&1 \
    && grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
